// File: mips_pkg.sv
package mips_pkg;

    // architectural data word
    localparam int WORD_W = 32;

    // request tag width, enough to tell in-flight divides apart
    localparam int TAG_W = 4;

    // dividend, divisor, quotient (LO) and remainder (HI)
    typedef logic [WORD_W-1:0] word_t;

    // returned unchanged with the result
    typedef logic [TAG_W-1:0] tag_t;

endpackage

// File: div_pkg.sv
package div_pkg;

    // one quotient bit per step
    localparam int STEP_W = 5;

    // lane FSM
    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_RUN,
        LANE_HOLD
    } lane_state_t;

    // step counter, 0 to 31
    typedef logic [STEP_W-1:0] step_t;

    // last step of a 32-bit divide
    localparam step_t STEP_LAST = step_t'(31);

endpackage

// File: div_dispatch.sv
module div_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [NUM_LANES-1:0] lane_idle,
    output logic [NUM_LANES-1:0] lane_start,
    output logic                 busy
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] pick;
    logic             found;
    logic             issue;

    // busy as soon as every lane is running or holding a result
    assign busy  = ~|lane_idle;
    assign issue = start && found;

    // first idle lane at or after the pointer, wrapping around
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(ptr) + k) % NUM_LANES;
            if (!found && lane_idle[idx]) begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
    end

    // start pulse to the chosen lane only
    always_comb begin
        lane_start = '0;
        if (issue) begin
            lane_start[pick] = 1'b1;
        end
    end

    // pointer moves past the lane just started
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (issue) begin
            if (int'(pick) == NUM_LANES - 1) begin
                ptr <= '0;
            end else begin
                ptr <= pick + 1'b1;
            end
        end
    end

endmodule

// File: div_lane.sv
module div_lane
    import mips_pkg::*;
    import div_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    input  tag_t  tag,
    input  logic  ack,
    output logic  idle,
    output logic  valid,
    output word_t quot,
    output word_t rem,
    output tag_t  tag_out
);

    lane_state_t state;
    step_t       step;
    word_t       divs;
    logic [32:0] trial;
    logic        take;

    assign idle  = (state == LANE_IDLE);
    assign valid = (state == LANE_HOLD);
    assign take  = idle && start;

    // shift the next dividend bit into the partial remainder and try the subtract
    assign trial = {rem, quot[31]} - {1'b0, divs};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LANE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        state <= LANE_RUN;
                        step  <= '0;
                    end
                end
                LANE_RUN: begin
                    step <= step + 1'b1;
                    if (step == STEP_LAST) begin
                        state <= LANE_HOLD;
                    end
                end
                LANE_HOLD: begin
                    // result stays put until the collector takes it
                    if (ack) begin
                        state <= LANE_IDLE;
                    end
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

    // quot starts as the dividend and fills with quotient bits from the right
    always_ff @(posedge clk) begin
        if (take) begin
            rem     <= '0;
            quot    <= dividend;
            divs    <= divisor;
            tag_out <= tag;
        end else if (state == LANE_RUN) begin
            if (!trial[32]) begin
                // subtract fits, keep the difference
                rem  <= trial[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                // restore, just keep the shifted remainder
                rem  <= {rem[30:0], quot[31]};
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

endmodule

// File: div_collect.sv
module div_collect
    import mips_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] lane_valid,
    input  word_t                lane_quot [NUM_LANES],
    input  word_t                lane_rem  [NUM_LANES],
    input  tag_t                 lane_tag  [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_ack,
    output logic                 done,
    output word_t                quotient,
    output word_t                remainder,
    output tag_t                 done_tag
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] grant;
    logic             found;

    // first finished lane at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        grant = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(ptr) + k) % NUM_LANES;
            if (!found && lane_valid[idx]) begin
                found = 1'b1;
                grant = IDX_W'(idx);
            end
        end
    end

    always_comb begin
        lane_ack = '0;
        if (found) begin
            lane_ack[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr  <= '0;
            done <= 1'b0;
        end else begin
            done <= found;
            if (found) begin
                ptr <= (int'(grant) == NUM_LANES - 1) ? '0 : grant + 1'b1;
            end
        end
    end

    // result registers, only meaningful with done
    always_ff @(posedge clk) begin
        if (found) begin
            quotient  <= lane_quot[grant];
            remainder <= lane_rem[grant];
            done_tag  <= lane_tag[grant];
        end
    end

endmodule

// File: divu_unit.sv
module divu_unit
    import mips_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    input  tag_t  tag,
    output logic  busy,
    output logic  done,
    output word_t quotient,
    output word_t remainder,
    output tag_t  done_tag
);

    logic [NUM_LANES-1:0] lane_idle;
    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ack;
    word_t                lane_quot [NUM_LANES];
    word_t                lane_rem  [NUM_LANES];
    tag_t                 lane_tag  [NUM_LANES];

    div_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .lane_idle  (lane_idle),
        .lane_start (lane_start),
        .busy       (busy)
    );

    // operands fan out to every lane, only the started one captures them
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .start    (lane_start[i]),
            .dividend (dividend),
            .divisor  (divisor),
            .tag      (tag),
            .ack      (lane_ack[i]),
            .idle     (lane_idle[i]),
            .valid    (lane_valid[i]),
            .quot     (lane_quot[i]),
            .rem      (lane_rem[i]),
            .tag_out  (lane_tag[i])
        );
    end

    div_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clk        (clk),
        .rst        (rst),
        .lane_valid (lane_valid),
        .lane_quot  (lane_quot),
        .lane_rem   (lane_rem),
        .lane_tag   (lane_tag),
        .lane_ack   (lane_ack),
        .done       (done),
        .quotient   (quotient),
        .remainder  (remainder),
        .done_tag   (done_tag)
    );

endmodule

// File: divu_unit_tb.sv
module divu_unit_tb
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES    = 4;
    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RAND     = 24;
    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_LANES + NUM_RAND + 8) * 40;
    localparam int NUM_TAGS     = 1 << TAG_W;
    localparam logic [31:0] SEED = 32'h96fc8d72;

    typedef struct {
        string name;
        word_t dividend;
        word_t divisor;
        word_t quot;
        word_t rem;
    } row_t;

    // expected values worked out by hand
    row_t directed_rows [NUM_DIRECTED] = '{
        '{"cpu_case",         32'hFEDC000A, 32'hE8BA0CDE, 32'h00000001, 32'h1621F32C},
        '{"zero_by_one",      32'h00000000, 32'h00000001, 32'h00000000, 32'h00000000},
        '{"max_by_one",       32'hFFFFFFFF, 32'h00000001, 32'hFFFFFFFF, 32'h00000000},
        '{"seven_by_zero",    32'h00000007, 32'h00000000, 32'hFFFFFFFF, 32'h00000007},
        '{"max_by_max",       32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000001, 32'h00000000},
        '{"hundred_by_seven", 32'h00000064, 32'h00000007, 32'h0000000E, 32'h00000002},
        '{"small_by_big",     32'h00000005, 32'h00000009, 32'h00000000, 32'h00000005},
        '{"shift_by_4k",      32'h12345678, 32'h00001000, 32'h00012345, 32'h00000678}
    };

    logic  clk;
    logic  rst;
    logic  start;
    word_t dividend;
    word_t divisor;
    tag_t  tag;
    logic  busy;
    logic  done;
    word_t quotient;
    word_t remainder;
    tag_t  done_tag;

    // scoreboard, indexed by tag
    word_t exp_q    [NUM_TAGS];
    word_t exp_r    [NUM_TAGS];
    string exp_name [NUM_TAGS];
    bit    pending  [NUM_TAGS];

    int   pass_count  = 0;
    int   fail_count  = 0;
    int   done_count  = 0;
    int   accepted    = 0;
    int   outstanding = 0;
    int   cycles      = 0;
    tag_t next_tag    = '0;

    divu_unit #(
        .NUM_LANES (NUM_LANES)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .tag       (tag),
        .busy      (busy),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder),
        .done_tag  (done_tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // divide by zero gives all ones, remainder is the dividend
    function automatic word_t expected_quotient(input word_t a, input word_t b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    function automatic word_t expected_remainder(input word_t a, input word_t b);
        if (b == '0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    // waits for a free lane, then issues on the next edge
    task automatic issue_op(input string name, input word_t a, input word_t b,
                            input word_t q, input word_t r, input tag_t t);
        while (busy !== 1'b0 || pending[t]) begin
            @(negedge clk);
        end
        start       = 1'b1;
        dividend    = a;
        divisor     = b;
        tag         = t;
        exp_q[t]    = q;
        exp_r[t]    = r;
        exp_name[t] = name;
        pending[t]  = 1'b1;
        outstanding++;
        accepted++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_drained();
        while (outstanding != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_result();
        tag_t t;
        bit   ok;
        t  = done_tag;
        ok = 1'b1;
        done_count++;
        assert (!$isunknown(t) && pending[t]) else begin
            $display("result with tag %0d arrived while no request with that tag was waiting",
                     t);
            ok = 1'b0;
        end
        if (ok) begin
            assert (quotient === exp_q[t]) else begin
                $display("MISMATCH %s quotient expected %h actual %h",
                         exp_name[t], exp_q[t], quotient);
                ok = 1'b0;
            end
            assert (remainder === exp_r[t]) else begin
                $display("MISMATCH %s remainder expected %h actual %h",
                         exp_name[t], exp_r[t], remainder);
                ok = 1'b0;
            end
            pending[t] = 1'b0;
            outstanding--;
            report_test(exp_name[t], ok);
        end else begin
            report_test("unexpected_tag", 1'b0);
        end
    endtask

    // outputs are read before this edge updates them
    always @(posedge clk) begin
        if (!rst && done === 1'b1) begin
            check_result();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d results still outstanding",
                     cycles, outstanding);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        word_t a;
        word_t b;
        tag_t  t;
        bit    ok;

        void'($urandom(SEED));
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i] = 1'b0;
        end
        rst      = 1'b1;
        start    = 1'b0;
        dividend = '0;
        divisor  = '0;
        tag      = '0;

        // busy and done stay low through reset and just after it
        ok = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (busy === 1'b0 && done === 1'b0) else begin
                $display("busy or done not low during reset (busy=%b done=%b)", busy, done);
                ok = 1'b0;
            end
        end
        rst = 1'b0;
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("busy or done not low after reset (busy=%b done=%b)", busy, done);
            ok = 1'b0;
        end
        report_test("reset_state", ok);

        // directed rows, one divide in flight at a time
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            t = next_tag;
            next_tag++;
            issue_op(directed_rows[i].name, directed_rows[i].dividend,
                     directed_rows[i].divisor, directed_rows[i].quot,
                     directed_rows[i].rem, t);
            while (pending[t]) begin
                @(negedge clk);
            end
        end

        // every lane busy, one extra start must be dropped
        wait_drained();
        ok = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            t = next_tag;
            next_tag++;
            // lanes still free, so the starts go out back to back
            assert (busy === 1'b0) else begin
                $display("busy high with only %0d of %0d lanes started", i, NUM_LANES);
                ok = 1'b0;
            end
            issue_op($sformatf("fill_%0d", i), a, b,
                     expected_quotient(a, b), expected_remainder(a, b), t);
        end
        assert (busy === 1'b1) else begin
            $display("busy did not rise with all %0d lanes started", NUM_LANES);
            ok = 1'b0;
        end
        start    = 1'b1;
        dividend = 32'h0000_0042;
        divisor  = 32'h0000_0003;
        tag      = next_tag;
        next_tag++;
        @(negedge clk);
        start = 1'b0;
        wait_drained();
        @(negedge clk);
        assert (busy === 1'b0) else begin
            $display("busy still high after all lane results drained");
            ok = 1'b0;
        end
        report_test("fill_lanes", ok);

        // overlapping random divides, some by zero
        for (int i = 0; i < NUM_RAND; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            if ($urandom % 8 == 0) begin
                b = '0;
            end
            t = next_tag;
            next_tag++;
            issue_op($sformatf("rand_%0d", i), a, b,
                     expected_quotient(a, b), expected_remainder(a, b), t);
        end
        wait_drained();

        // quiet window longer than one divide, no stray result may appear
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
        end
        ok = 1'b1;
        assert (done_count == accepted) else begin
            $display("%0d done pulses seen for %0d accepted starts", done_count, accepted);
            ok = 1'b0;
        end
        report_test("result_count", ok);

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
mips_pkg.sv
div_pkg.sv
div_dispatch.sv
div_lane.sv
div_collect.sv
divu_unit.sv
divu_unit_tb.sv

// File: Bender.yml
package:
  name: divu_unit

sources:
  - mips_pkg.sv
  - div_pkg.sv
  - div_dispatch.sv
  - div_lane.sv
  - div_collect.sv
  - divu_unit.sv
  - target: simulation
    files:
      - divu_unit_tb.sv
